/* logic/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // bit positions in alu_op_t
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef logic [11:0] alu_op_t;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jirl,
        br_b,
        br_bl
    } br_kind_e;

    // major opcode groups, inst[31:26]
    localparam logic [5:0] op_arith     = 6'h00;
    localparam logic [5:0] op_lu12i     = 6'h05;
    localparam logic [5:0] op_pcaddu12i = 6'h07;
    localparam logic [5:0] op_mem       = 6'h0a;
    localparam logic [5:0] op_jirl      = 6'h13;
    localparam logic [5:0] op_b         = 6'h14;
    localparam logic [5:0] op_bl        = 6'h15;
    localparam logic [5:0] op_beq       = 6'h16;
    localparam logic [5:0] op_bne       = 6'h17;
    localparam logic [5:0] op_blt       = 6'h18;
    localparam logic [5:0] op_bge       = 6'h19;
    localparam logic [5:0] op_bltu      = 6'h1a;
    localparam logic [5:0] op_bgeu      = 6'h1b;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fs_to_ds_t;

    // result feedback from a later stage
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       result;
    } fwd_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  load_op;
        logic                  mem_we;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rj_value;
        logic [xlen-1:0]       rkd_value;
        logic [xlen-1:0]       pc;
    } ds_to_es_t;

    typedef struct packed {
        alu_op_t               alu_op;
        br_kind_e              br_kind;
        logic                  load_op;
        logic                  mem_we;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [reg_addr_w-1:0] raddr1;
        logic [reg_addr_w-1:0] raddr2;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       offs;
    } dec_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } br_t;

endpackage

`default_nettype wire

/* logic/ds_latch.sv */
`timescale 1ns/1ns
`default_nettype none

module ds_latch (
    input  logic              clk,
    input  logic              reset,
    input  logic              fs_to_ds_valid,
    input  id_pkg::fs_to_ds_t fs_to_ds_bus,
    input  logic              es_allowin,
    input  logic              stall,
    output logic              ds_allowin,
    output logic              ds_valid,
    output logic              ds_to_es_valid,
    output id_pkg::fs_to_ds_t ds_bus
);

    logic ds_ready_go;

    assign ds_ready_go    = !stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    // stall only comes from an occupied stage
    a_stall_valid: assert property (@(posedge clk) disable iff (reset)
        stall |-> ds_valid);

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  logic [31:0]  inst,
    output id_pkg::dec_t dec
);
    import id_pkg::*;

    always_comb begin
        logic [5:0] op6;
        logic [3:0] op4;
        logic [4:0] op5;
        logic       is_ari;
        logic       is_3r;
        logic       is_shi;
        logic       is_add, is_sub, is_slt, is_sltu;
        logic       is_and, is_nor, is_or, is_xor;
        logic       is_sll, is_srl, is_sra;
        logic       is_slli, is_srli, is_srai;
        logic       is_addi, is_slti, is_sltui;
        logic       is_andi, is_ori, is_xori;
        logic       is_lu12i, is_pcaddu12i;
        logic       is_ld_w, is_st_w;
        logic       is_jirl, is_b, is_bl;
        logic       is_cond_br;

        op6 = inst[31:26];
        op4 = inst[25:22];
        op5 = inst[19:15];

        is_ari = (op6 == op_arith);
        is_3r  = is_ari && (op4 == 4'h0) && (inst[21:20] == 2'b01);
        is_shi = is_ari && (op4 == 4'h1) && (inst[21:20] == 2'b00);

        is_add  = is_3r && (op5 == 5'h00);
        is_sub  = is_3r && (op5 == 5'h02);
        is_slt  = is_3r && (op5 == 5'h04);
        is_sltu = is_3r && (op5 == 5'h05);
        is_nor  = is_3r && (op5 == 5'h08);
        is_and  = is_3r && (op5 == 5'h09);
        is_or   = is_3r && (op5 == 5'h0a);
        is_xor  = is_3r && (op5 == 5'h0b);
        is_sll  = is_3r && (op5 == 5'h0e);
        is_srl  = is_3r && (op5 == 5'h0f);
        is_sra  = is_3r && (op5 == 5'h10);
        is_slli = is_shi && (op5 == 5'h01);
        is_srli = is_shi && (op5 == 5'h09);
        is_srai = is_shi && (op5 == 5'h11);

        is_slti  = is_ari && (op4 == 4'h8);
        is_sltui = is_ari && (op4 == 4'h9);
        is_addi  = is_ari && (op4 == 4'ha);
        is_andi  = is_ari && (op4 == 4'hd);
        is_ori   = is_ari && (op4 == 4'he);
        is_xori  = is_ari && (op4 == 4'hf);

        is_lu12i     = (op6 == op_lu12i) && !inst[25];
        is_pcaddu12i = (op6 == op_pcaddu12i) && !inst[25];
        is_ld_w      = (op6 == op_mem) && (op4 == 4'h2);
        is_st_w      = (op6 == op_mem) && (op4 == 4'h6);
        is_jirl      = (op6 == op_jirl);
        is_b         = (op6 == op_b);
        is_bl        = (op6 == op_bl);
        is_cond_br   = (op6 >= op_beq) && (op6 <= op_bgeu);

        dec = '0;

        // address arithmetic and link values go through the adder
        dec.alu_op[alu_add]  = is_add | is_addi | is_ld_w | is_st_w
                             | is_jirl | is_bl | is_pcaddu12i;
        dec.alu_op[alu_sub]  = is_sub;
        dec.alu_op[alu_slt]  = is_slt | is_slti;
        dec.alu_op[alu_sltu] = is_sltu | is_sltui;
        dec.alu_op[alu_and]  = is_and | is_andi;
        dec.alu_op[alu_nor]  = is_nor;
        dec.alu_op[alu_or]   = is_or | is_ori;
        dec.alu_op[alu_xor]  = is_xor | is_xori;
        dec.alu_op[alu_sll]  = is_sll | is_slli;
        dec.alu_op[alu_srl]  = is_srl | is_srli;
        dec.alu_op[alu_sra]  = is_sra | is_srai;
        dec.alu_op[alu_lui]  = is_lu12i;

        case (op6)
            op_beq:  dec.br_kind = br_beq;
            op_bne:  dec.br_kind = br_bne;
            op_blt:  dec.br_kind = br_blt;
            op_bge:  dec.br_kind = br_bge;
            op_bltu: dec.br_kind = br_bltu;
            op_bgeu: dec.br_kind = br_bgeu;
            op_jirl: dec.br_kind = br_jirl;
            op_b:    dec.br_kind = br_b;
            op_bl:   dec.br_kind = br_bl;
            default: dec.br_kind = br_none;
        endcase

        dec.load_op     = is_ld_w;
        dec.mem_we      = is_st_w;
        dec.src1_is_pc  = is_jirl | is_bl | is_pcaddu12i;
        dec.src2_is_imm = is_slli | is_srli | is_srai | is_addi | is_slti | is_sltui
                        | is_andi | is_ori | is_xori | is_ld_w | is_st_w
                        | is_lu12i | is_pcaddu12i | is_jirl | is_bl;
        // every alu user writes back except the store
        dec.gr_we       = (|dec.alu_op) && !is_st_w;

        dec.dest   = is_bl ? 5'd1 : inst[4:0];
        dec.raddr1 = inst[9:5];
        dec.raddr2 = (is_cond_br || is_st_w) ? inst[4:0] : inst[14:10];

        if (is_jirl || is_bl) begin
            dec.imm = 32'd4;
        end else if (is_andi || is_ori || is_xori) begin
            dec.imm = {20'b0, inst[21:10]};
        end else if (is_lu12i || is_pcaddu12i) begin
            dec.imm = {inst[24:5], 12'b0};
        end else begin
            dec.imm = {{20{inst[21]}}, inst[21:10]};
        end

        // si26 is split, high part sits in inst[9:0]
        if (is_b || is_bl) begin
            dec.offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end else begin
            dec.offs = {{14{inst[25]}}, inst[25:10], 2'b00};
        end

        a_alu_onehot: assert ($isunknown(inst) || $onehot0(dec.alu_op))
            else $error("alu_op has more than one bit set");
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic [id_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_pkg::reg_addr_w-1:0] raddr2,
    output logic [id_pkg::xlen-1:0]       rdata1,
    output logic [id_pkg::xlen-1:0]       rdata2,
    input  id_pkg::fwd_t                  wr
);
    import id_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (wr.we && (wr.dest != '0)) begin
            regs[wr.dest] <= wr.result;
        end
    end

    // r0 is never written, reads of it are forced
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* logic/operand_forward.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
    input  logic                    clk,
    input  id_pkg::dec_t            dec,
    input  logic                    ds_valid,
    input  id_pkg::fwd_t            es_fwd,
    input  id_pkg::fwd_t            ms_fwd,
    input  id_pkg::fwd_t            ws_fwd,
    input  logic                    es_load,
    output logic [id_pkg::xlen-1:0] rj_value,
    output logic [id_pkg::xlen-1:0] rkd_value,
    output logic                    stall
);
    import id_pkg::*;

    logic [xlen-1:0] rf_rdata1;
    logic [xlen-1:0] rf_rdata2;

    function automatic logic hit(fwd_t src, logic [reg_addr_w-1:0] addr);
        return src.we && (src.dest == addr) && (addr != '0);
    endfunction

    // youngest producer first
    function automatic logic [xlen-1:0] pick(logic [reg_addr_w-1:0] addr,
                                             logic [xlen-1:0] rf_data);
        if (hit(es_fwd, addr)) begin
            return es_fwd.result;
        end else if (hit(ms_fwd, addr)) begin
            return ms_fwd.result;
        end else if (hit(ws_fwd, addr)) begin
            return ws_fwd.result;
        end
        return rf_data;
    endfunction

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .raddr2 (dec.raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_fwd)
    );

    always_comb begin
        rj_value  = pick(dec.raddr1, rf_rdata1);
        rkd_value = pick(dec.raddr2, rf_rdata2);
    end

    // load data is not ready until mem, wait for it
    assign stall = ds_valid && es_load && (es_fwd.dest != '0)
                && ((es_fwd.dest == dec.raddr1) || (es_fwd.dest == dec.raddr2));

    // r0 reads zero on every path, bypassed or not
    a_r0_rj: assert property (@(posedge clk) (dec.raddr1 == '0) |-> (rj_value == '0));
    a_r0_rkd: assert property (@(posedge clk) (dec.raddr2 == '0) |-> (rkd_value == '0));

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  id_pkg::dec_t            dec,
    input  logic                    ds_valid,
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] rj_value,
    input  logic [id_pkg::xlen-1:0] rkd_value,
    output id_pkg::br_t             br_bus
);
    import id_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    always_comb begin
        case (dec.br_kind)
            br_beq:  cond = eq;
            br_bne:  cond = !eq;
            br_blt:  cond = lt_s;
            br_bge:  cond = !lt_s;
            br_bltu: cond = lt_u;
            br_bgeu: cond = !lt_u;
            br_jirl, br_b, br_bl: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign br_bus.taken  = ds_valid && cond;
    // jirl is register relative, the rest pc relative
    assign br_bus.target = ((dec.br_kind == br_jirl) ? rj_value : pc) + dec.offs;

endmodule

`default_nettype wire

/* logic/id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              fs_to_ds_valid,
    input  id_pkg::fs_to_ds_t fs_to_ds_bus,
    output logic              ds_allowin,
    output logic              ds_to_es_valid,
    output id_pkg::ds_to_es_t ds_to_es_bus,
    output id_pkg::br_t       br_bus,
    input  logic              es_allowin,
    input  id_pkg::fwd_t      es_fwd,
    input  logic              es_load,
    input  id_pkg::fwd_t      ms_fwd,
    input  id_pkg::fwd_t      ws_fwd
);
    import id_pkg::*;

    logic            ds_valid;
    logic            stall;
    fs_to_ds_t       ds_bus;
    dec_t            dec;
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;

    ds_latch u_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .stall          (stall),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_bus         (ds_bus)
    );

    inst_decoder u_dec (
        .inst (ds_bus.inst),
        .dec  (dec)
    );

    operand_forward u_fwd (
        .clk       (clk),
        .dec       (dec),
        .ds_valid  (ds_valid),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_fwd    (ws_fwd),
        .es_load   (es_load),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_br (
        .dec       (dec),
        .ds_valid  (ds_valid),
        .pc        (ds_bus.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_bus    (br_bus)
    );

    assign ds_to_es_bus = '{
        alu_op:      dec.alu_op,
        load_op:     dec.load_op,
        mem_we:      dec.mem_we,
        src1_is_pc:  dec.src1_is_pc,
        src2_is_imm: dec.src2_is_imm,
        gr_we:       dec.gr_we,
        dest:        dec.dest,
        imm:         dec.imm,
        rj_value:    rj_value,
        rkd_value:   rkd_value,
        pc:          ds_bus.pc
    };

endmodule

`default_nettype wire

/* include/tb_vectors.svh */
`ifndef tb_vectors_svh
`define tb_vectors_svh

// one table step, remaining expected fields come from the reference model
typedef struct packed {
    logic [79:0]  name;
    logic [31:0]  inst;
    logic [31:0]  pc;
    id_pkg::fwd_t es;
    id_pkg::fwd_t ms;
    id_pkg::fwd_t ws;
    logic         es_load;
    logic         es_allowin;
    logic         exp_stall;
} tb_vec_t;

localparam id_pkg::fwd_t fwd_none  = '0;
localparam id_pkg::fwd_t fwd_es_r1 = {1'b1, 5'd1, 32'hee00_0001};
localparam id_pkg::fwd_t fwd_ms_r1 = {1'b1, 5'd1, 32'hdd00_0001};
localparam id_pkg::fwd_t fwd_ws_r1 = {1'b1, 5'd1, 32'hcc00_0001};
localparam id_pkg::fwd_t fwd_ws_r2 = {1'b1, 5'd2, 32'hcc00_0002};
localparam id_pkg::fwd_t fwd_es_r0 = {1'b1, 5'd0, 32'hbad0_0000};

// registers written through ws_fwd before the table
localparam int n_preload = 7;
localparam logic [4:0] preload_regs [n_preload] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7};

localparam int n_vectors = 27;
localparam tb_vec_t vectors [n_vectors] = '{
    '{"add_w",    32'h0010_0823, 32'h1c00_0000, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"addi_w",   32'h02bf_fc24, 32'h1c00_0004, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"fwd_all", 32'h0010_0823, 32'h1c00_0008, fwd_es_r1, fwd_ms_r1, fwd_ws_r1, 1'b0, 1'b1, 1'b0},
    '{"fwd_ms",   32'h0010_0823, 32'h1c00_000c, fwd_none, fwd_ms_r1, fwd_ws_r1, 1'b0, 1'b1, 1'b0},
    '{"fwd_ws",   32'h0010_0823, 32'h1c00_0010, fwd_none, fwd_none, fwd_ws_r2, 1'b0, 1'b1, 1'b0},
    '{"rd_zero",  32'h0010_0803, 32'h1c00_0014, fwd_es_r0, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"andi",     32'h0360_0025, 32'h1c00_0018, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"lu12i_w",  32'h1424_68a6, 32'h1c00_001c, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"ld_w",     32'h28bf_f027, 32'h1c00_0020, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"st_w",     32'h2980_2022, 32'h1c00_0024, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bl",       32'h5401_0000, 32'h1c00_0028, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"beq",      32'h5800_1022, 32'h1c00_0100, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"beq_same", 32'h5800_1021, 32'h1c00_0104, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bne",      32'h5c00_1022, 32'h1c00_0108, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bne_same", 32'h5c00_1021, 32'h1c00_010c, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"blt",      32'h6000_1020, 32'h1c00_0110, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"blt_rev",  32'h6000_1001, 32'h1c00_0114, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bge",      32'h6400_1020, 32'h1c00_0118, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bge_rev",  32'h6400_1001, 32'h1c00_011c, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bltu",     32'h6800_1020, 32'h1c00_0120, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bltu_rev", 32'h6800_1001, 32'h1c00_0124, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bgeu",     32'h6c00_1020, 32'h1c00_0128, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"bgeu_rev", 32'h6c00_1001, 32'h1c00_012c, fwd_es_r1, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"jirl",     32'h4c00_0820, 32'h1c00_0130, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"b",        32'h53ff_fbff, 32'h1c00_0134, fwd_none, fwd_none, fwd_none, 1'b0, 1'b1, 1'b0},
    '{"load_use", 32'h0010_0823, 32'h1c00_0200, fwd_es_r1, fwd_none, fwd_none, 1'b1, 1'b1, 1'b1},
    '{"back_prs", 32'h0010_0823, 32'h1c00_0204, fwd_none, fwd_none, fwd_none, 1'b0, 1'b0, 1'b0}
};

`endif

/* sim/tb_id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    `include "tb_vectors.svh"

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds_bus;
    logic      ds_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    br_t       br_bus;
    logic      es_allowin;
    fwd_t      es_fwd;
    logic      es_load;
    fwd_t      ms_fwd;
    fwd_t      ws_fwd;

    logic [31:0] lfsr_state;
    logic [31:0] ref_regs [32];
    int          errors;
    int          checks;

    id_stage dut0 (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus),
        .es_allowin     (es_allowin),
        .es_fwd         (es_fwd),
        .es_load        (es_load),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // preload, reset and a worst case of 20 cycles per table entry
    initial begin
        #((5 + n_preload + 4 + n_vectors * 20) * 100);
        $display("watchdog expired, the DUT never finished the table");
        $display("Finished with errors");
        $finish;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [4:0] ref_raddr2(input logic [31:0] inst);
        logic cond_br;
        cond_br = (inst[31:26] >= 6'h16) && (inst[31:26] <= 6'h1b);
        return (cond_br || (inst[31:22] == 10'h0a6)) ? inst[4:0] : inst[14:10];
    endfunction

    // youngest matching producer wins, r0 is always zero
    function automatic logic [31:0] ref_operand(input logic [4:0] addr, input fwd_t es,
                                                input fwd_t ms, input fwd_t ws);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (es.we && es.dest == addr) begin
            return es.result;
        end else if (ms.we && ms.dest == addr) begin
            return ms.result;
        end else if (ws.we && ws.dest == addr) begin
            return ws.result;
        end
        return ref_regs[addr];
    endfunction

    function automatic ds_to_es_t ref_bus(input logic [31:0] inst, input logic [31:0] pc,
                                          input logic [31:0] rj, input logic [31:0] rkd);
        ds_to_es_t   e;
        logic [16:0] op17;
        logic [9:0]  op10;
        logic [6:0]  op7;
        logic        link;
        logic        zext;
        logic        hi20;
        int          k;
        e = '0;
        op17 = inst[31:15];
        op10 = inst[31:22];
        op7 = inst[31:25];
        link = (inst[31:26] == 6'h13) || (inst[31:26] == 6'h15);
        zext = op10 inside {10'h00d, 10'h00e, 10'h00f};
        hi20 = (op7 == 7'h0a) || (op7 == 7'h0e);
        k = -1;
        case (op17)
            17'h20: k = 0;
            17'h22: k = 1;
            17'h24: k = 2;
            17'h25: k = 3;
            17'h29: k = 4;
            17'h28: k = 5;
            17'h2a: k = 6;
            17'h2b: k = 7;
            17'h2e, 17'h81: k = 8;
            17'h2f, 17'h89: k = 9;
            17'h30, 17'h91: k = 10;
            default: ;
        endcase
        case (op10)
            10'h008: k = 2;
            10'h009: k = 3;
            10'h00a, 10'h0a2, 10'h0a6: k = 0;
            10'h00d: k = 4;
            10'h00e: k = 6;
            10'h00f: k = 7;
            default: ;
        endcase
        if (op7 == 7'h0a) begin
            k = 11;
        end else if (op7 == 7'h0e || link) begin
            k = 0;
        end
        e.load_op = (op10 == 10'h0a2);
        e.mem_we = (op10 == 10'h0a6);
        e.src1_is_pc = link || (op7 == 7'h0e);
        e.src2_is_imm = (op17 inside {17'h81, 17'h89, 17'h91}) || hi20 || link
                      || (op10 inside {10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e,
                                       10'h00f, 10'h0a2, 10'h0a6});
        if (k >= 0) begin
            e.alu_op[k] = 1'b1;
            e.gr_we = !e.mem_we;
        end
        e.dest = (inst[31:26] == 6'h15) ? 5'd1 : inst[4:0];
        if (link) begin
            e.imm = 32'd4;
        end else if (zext) begin
            e.imm = {20'd0, inst[21:10]};
        end else if (hi20) begin
            e.imm = {inst[24:5], 12'd0};
        end else begin
            e.imm = {{20{inst[21]}}, inst[21:10]};
        end
        e.rj_value = rj;
        e.rkd_value = rkd;
        e.pc = pc;
        return e;
    endfunction

    function automatic br_t ref_branch(input logic [31:0] inst, input logic [31:0] pc,
                                       input logic [31:0] rj, input logic [31:0] rkd);
        br_t         b;
        logic [5:0]  op6;
        logic [31:0] offs;
        op6 = inst[31:26];
        if (op6 == 6'h14 || op6 == 6'h15) begin
            offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end else begin
            offs = {{14{inst[25]}}, inst[25:10], 2'b00};
        end
        case (op6)
            6'h16: b.taken = (rj == rkd);
            6'h17: b.taken = (rj != rkd);
            6'h18: b.taken = ($signed(rj) < $signed(rkd));
            6'h19: b.taken = ($signed(rj) >= $signed(rkd));
            6'h1a: b.taken = (rj < rkd);
            6'h1b: b.taken = (rj >= rkd);
            6'h13, 6'h14, 6'h15: b.taken = 1'b1;
            default: b.taken = 1'b0;
        endcase
        b.target = ((op6 == 6'h13) ? rj : pc) + offs;
        return b;
    endfunction

    task automatic check_bit(input logic [79:0] tname, input string field,
                             input logic exp_v, input logic act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Fail %0s %0s: expected %b, actual %b", tname, field, exp_v, act_v);
        end
    endtask

    task automatic check_word(input logic [79:0] tname, input string field,
                              input logic [31:0] exp_v, input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Fail %0s %0s: expected %h, actual %h", tname, field, exp_v, act_v);
        end
    endtask

    task automatic check_bus(input logic [79:0] tname, input ds_to_es_t exp_v);
        checks++;
        if (exp_v !== ds_to_es_bus) begin
            errors++;
            $display("Fail %0s ds_to_es_bus: expected %h, actual %h",
                     tname, exp_v, ds_to_es_bus);
        end
    endtask

    task automatic next_drive();
        @(posedge clk);
        #5;
    endtask

    task automatic apply_vector(input tb_vec_t t);
        ds_to_es_t   exp_bus;
        br_t         exp_br;
        logic [31:0] rj;
        logic [31:0] rkd;
        int          n;
        next_drive();
        while (!ds_allowin) begin
            next_drive();
        end
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus = '{pc: t.pc, inst: t.inst};
        es_fwd = t.es;
        ms_fwd = t.ms;
        es_load = t.es_load;
        es_allowin = t.es_allowin;
        next_drive();
        fs_to_ds_valid = 1'b0;
        // writeback lands in the read cycle, before its own register write
        ws_fwd = t.ws;
        #40;
        rj = ref_operand(t.inst[9:5], t.es, t.ms, t.ws);
        rkd = ref_operand(ref_raddr2(t.inst), t.es, t.ms, t.ws);
        exp_bus = ref_bus(t.inst, t.pc, rj, rkd);
        exp_br = ref_branch(t.inst, t.pc, rj, rkd);
        check_bit(t.name, "ds_to_es_valid", !t.exp_stall, ds_to_es_valid);
        check_bit(t.name, "br_taken", exp_br.taken, br_bus.taken);
        if (exp_br.taken) begin
            check_word(t.name, "br_target", exp_br.target, br_bus.target);
        end
        if (t.exp_stall) begin
            check_bit(t.name, "ds_allowin", 1'b0, ds_allowin);
            n = 1 + int'(rand_bits(2));
            repeat (n) begin
                @(posedge clk);
                #45;
                check_bit(t.name, "stall_valid", 1'b0, ds_to_es_valid);
                check_bit(t.name, "stall_allowin", 1'b0, ds_allowin);
            end
            // load result leaves execute
            next_drive();
            es_load = 1'b0;
            es_fwd = '0;
            #40;
            rj = ref_operand(t.inst[9:5], '0, t.ms, t.ws);
            rkd = ref_operand(ref_raddr2(t.inst), '0, t.ms, t.ws);
            exp_bus = ref_bus(t.inst, t.pc, rj, rkd);
            check_bit(t.name, "released_valid", 1'b1, ds_to_es_valid);
        end
        check_bus(t.name, exp_bus);
        if (!t.es_allowin) begin
            check_bit(t.name, "ds_allowin", 1'b0, ds_allowin);
            next_drive();
            fs_to_ds_valid = 1'b1;
            fs_to_ds_bus = '{pc: t.pc + 32'h100, inst: t.inst};
            repeat (2) begin
                @(posedge clk);
                #45;
                check_bit(t.name, "held_allowin", 1'b0, ds_allowin);
                check_bit(t.name, "held_valid", 1'b1, ds_to_es_valid);
                check_bus(t.name, exp_bus);
            end
            next_drive();
            es_allowin = 1'b1;
            next_drive();
            fs_to_ds_valid = 1'b0;
            #40;
            check_word(t.name, "second_pc", t.pc + 32'h100, ds_to_es_bus.pc);
        end
        next_drive();
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        es_load = 1'b0;
        es_allowin = 1'b1;
        if (t.ws.we && t.ws.dest != 5'd0) begin
            ref_regs[t.ws.dest] = t.ws.result;
        end
        @(posedge clk);
        #45;
        check_bit(t.name, "empty_valid", 1'b0, ds_to_es_valid);
        check_bit(t.name, "empty_taken", 1'b0, br_bus.taken);
    endtask

    initial begin
        lfsr_state = 32'h3596_b8a9;
        errors = 0;
        checks = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        es_load = 1'b0;
        ms_fwd = '0;
        ws_fwd = '0;
        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;
        #40;
        check_bit("reset", "ds_to_es_valid", 1'b0, ds_to_es_valid);
        check_bit("reset", "br_taken", 1'b0, br_bus.taken);
        check_bit("reset", "ds_allowin", 1'b1, ds_allowin);

        // registers filled through the writeback port
        for (int i = 0; i < n_preload; i++) begin
            next_drive();
            ws_fwd = '{we: 1'b1, dest: preload_regs[i], result: rand_bits(32)};
            ref_regs[preload_regs[i]] = ws_fwd.result;
        end
        next_drive();
        ws_fwd = '0;

        for (int v = 0; v < n_vectors; v++) begin
            apply_vector(vectors[v]);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
logic/id_pkg.sv
logic/ds_latch.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/id_stage.sv
sim/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the id_stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_id_stage \
    -o tb_id_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_id_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
    exit 0
fi
exit 1
